// ==== common/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

  //--------------------------------------------------------------------------
  // Cache geometry
  //--------------------------------------------------------------------------
  // Two ways of 32 sets
  localparam int NUM_WAYS    = 2;
  localparam int LINE_ADDR_W = 5;
  localparam int NUM_LINES   = 32;

  // 8 byte line, one instruction pair
  localparam int LINE_SIZE_W = 3;
  localparam int DATA_W      = 64;

  // Tag is everything above set index
  localparam int TAG_W       = 32 - LINE_ADDR_W - LINE_SIZE_W;

  //--------------------------------------------------------------------------
  // AXI read constants
  //--------------------------------------------------------------------------
  // Two 32-bit beats per line
  localparam logic [7:0] AXI_ARLEN   = 8'd1;
  // INCR
  localparam logic [1:0] AXI_ARBURST = 2'd1;
  localparam logic [3:0] AXI_ID      = 4'd0;

  // Controller states
  typedef enum logic [1:0] {
    FLUSH    = 2'd0,
    LOOKUP   = 2'd1,
    REFILL   = 2'd2,
    RELOOKUP = 2'd3
  } state_e;

  // Tag array entry
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } tag_entry_t;

  typedef logic [LINE_ADDR_W-1:0] line_idx_t;

  // AR channel, ID/len/burst are constant
  typedef struct packed {
    logic        arvalid;
    logic [31:0] araddr;
  } axi_ar_t;

  // R channel
  typedef struct packed {
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rlast;
  } axi_r_t;

  // Write shared by both ways, steered per way by the strobes
  typedef struct packed {
    logic              tag_wr;
    logic              data_wr;
    tag_entry_t        tag;
    logic [DATA_W-1:0] data;
  } ram_wr_t;

endpackage

`default_nettype wire

// ==== way/icache_way.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_way (
  input  wire                                clk_i,
  input  wire  icache_pkg::line_idx_t        line_idx_i,
  input  wire  [icache_pkg::LINE_ADDR_W-1:0] data_addr_i,
  input  wire  [icache_pkg::TAG_W-1:0]       cmp_tag_i,
  input  wire                                tag_wr_i,
  input  wire                                data_wr_i,
  input  wire  icache_pkg::ram_wr_t          wr_i,
  output logic                               hit_o,
  output logic [icache_pkg::DATA_W-1:0]      data_o
);

  // Tag and data arrays
  icache_pkg::tag_entry_t        tag_ram  [icache_pkg::NUM_LINES];
  logic [icache_pkg::DATA_W-1:0] data_ram [icache_pkg::NUM_LINES];

  icache_pkg::tag_entry_t        tag_rd_q;

  //--------------------------------------------------------------------------
  // Tag array
  //--------------------------------------------------------------------------
  // Read returns the old entry on a write cycle
  always_ff @(posedge clk_i)
  begin
    if (tag_wr_i)
      tag_ram[line_idx_i] <= wr_i.tag;
    tag_rd_q <= tag_ram[line_idx_i];
  end

  // Valid entry with matching tag
  assign hit_o = tag_rd_q.valid && (tag_rd_q.tag == cmp_tag_i);

  //--------------------------------------------------------------------------
  // Data array
  //--------------------------------------------------------------------------
  always_ff @(posedge clk_i)
  begin
    if (data_wr_i)
      data_ram[data_addr_i] <= wr_i.data;
    data_o <= data_ram[data_addr_i];
  end

endmodule

`default_nettype wire

// ==== src/icache_way_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_way_select (
  input  wire                               clk_i,
  input  wire                               rst_i,
  input  wire                               hit0_i,
  input  wire                               hit1_i,
  input  wire  [icache_pkg::DATA_W-1:0]     data0_i,
  input  wire  [icache_pkg::DATA_W-1:0]     data1_i,
  input  wire                               flush_wr_i,
  input  wire  icache_pkg::ram_wr_t         wr_i,
  output logic                              hit_any_o,
  output logic [icache_pkg::DATA_W-1:0]     inst_o,
  output logic [icache_pkg::NUM_WAYS-1:0]   tag_wr_o,
  output logic [icache_pkg::NUM_WAYS-1:0]   data_wr_o
);

  // Way to fill next
  logic replace_q;

  assign hit_any_o = hit0_i || hit1_i;

  // Way 0 wins, both never hit together
  assign inst_o = hit0_i ? data0_i : data1_i;

  // Round robin, step once per filled line
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      replace_q <= 1'b0;
    else if (wr_i.tag_wr)
      replace_q <= ~replace_q;
  end

  // Refill goes to the named way, flush clears both
  always_comb
  begin
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++)
    begin
      tag_wr_o[w]  = flush_wr_i || (wr_i.tag_wr && (int'(replace_q) == w));
      data_wr_o[w] = wr_i.data_wr && (int'(replace_q) == w);
    end
  end

endmodule

`default_nettype wire

// ==== controller/icache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
  input  wire                                clk_i,
  input  wire                                rst_i,
  input  wire                                req_rd_i,
  input  wire                                req_flush_i,
  input  wire                                req_invalidate_i,
  input  wire  [31:0]                        req_pc_i,
  input  wire                                hit_any_i,
  input  wire                                refill_done_i,
  input  wire  [icache_pkg::LINE_ADDR_W-1:0] refill_addr_i,
  output logic                               req_accept_o,
  output logic                               req_valid_o,
  output logic                               miss_o,
  output logic [31:0]                        lookup_addr_o,
  output icache_pkg::line_idx_t              line_idx_o,
  output logic [icache_pkg::LINE_ADDR_W-1:0] data_addr_o,
  output logic [icache_pkg::TAG_W-1:0]       cmp_tag_o,
  output logic                               flush_wr_o,
  output icache_pkg::state_e                 state_o
);

  icache_pkg::state_e    state_q;
  icache_pkg::state_e    next_state;
  logic                  lookup_valid_q;
  logic [31:0]           lookup_addr_q;
  icache_pkg::line_idx_t flush_addr_q;
  logic                  invalidate_q;
  icache_pkg::line_idx_t req_line;
  icache_pkg::line_idx_t lookup_line;
  logic                  in_lookup;

  // Set index of the incoming and the registered fetch
  assign req_line    = req_pc_i[icache_pkg::LINE_SIZE_W +: icache_pkg::LINE_ADDR_W];
  assign lookup_line = lookup_addr_q[icache_pkg::LINE_SIZE_W +: icache_pkg::LINE_ADDR_W];
  assign in_lookup   = (state_q == icache_pkg::LOOKUP);

  // Way outputs belong to the fetch registered last cycle
  assign miss_o       = in_lookup && lookup_valid_q && !hit_any_i;
  assign req_valid_o  = in_lookup && lookup_valid_q && hit_any_i;
  assign req_accept_o = in_lookup && !miss_o;

  //--------------------------------------------------------------------------
  // Lookup register
  //--------------------------------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      lookup_valid_q <= 1'b0;
    else if (req_rd_i && req_accept_o)
      lookup_valid_q <= 1'b1;
    else if (req_valid_o)
      lookup_valid_q <= 1'b0;
  end

  // Fetch address, held through the refill
  always_ff @(posedge clk_i)
  begin
    if (req_rd_i && req_accept_o)
      lookup_addr_q <= req_pc_i;
  end

  assign lookup_addr_o = lookup_addr_q;
  assign cmp_tag_o     = lookup_addr_q[31 -: icache_pkg::TAG_W];

  //--------------------------------------------------------------------------
  // Flush counter and invalidate
  //--------------------------------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      flush_addr_q <= '0;
      invalidate_q <= 1'b0;
    end
    else
    begin
      invalidate_q <= req_invalidate_i && req_accept_o;
      // Walk all sets
      if (state_q == icache_pkg::FLUSH)
        flush_addr_q <= flush_addr_q + 1'b1;
      // Single line, one FLUSH cycle
      else if (req_invalidate_i && req_accept_o)
        flush_addr_q <= req_line;
      else
        flush_addr_q <= '0;
    end
  end

  assign flush_wr_o = (state_q == icache_pkg::FLUSH);

  //--------------------------------------------------------------------------
  // FSM
  //--------------------------------------------------------------------------
  always_comb
  begin
    next_state = state_q;
    case (state_q)
      icache_pkg::FLUSH:
        if (invalidate_q || (flush_addr_q == '1))
          next_state = icache_pkg::LOOKUP;
      icache_pkg::LOOKUP:
        if (miss_o)
          next_state = icache_pkg::REFILL;
        else if (req_invalidate_i || req_flush_i)
          next_state = icache_pkg::FLUSH;
      icache_pkg::REFILL:
        if (refill_done_i)
          next_state = icache_pkg::RELOOKUP;
      // Re-read the freshly written line
      default:
        next_state = icache_pkg::LOOKUP;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      state_q <= icache_pkg::FLUSH;
    else
      state_q <= next_state;
  end

  assign state_o = state_q;

  //--------------------------------------------------------------------------
  // Array address select
  //--------------------------------------------------------------------------
  always_comb
  begin
    line_idx_o  = req_line;
    data_addr_o = req_line;
    case (state_q)
      icache_pkg::FLUSH:
        line_idx_o = flush_addr_q;
      icache_pkg::REFILL:
      begin
        line_idx_o  = lookup_line;
        data_addr_o = refill_addr_i;
      end
      icache_pkg::RELOOKUP:
      begin
        line_idx_o  = lookup_line;
        data_addr_o = lookup_line;
      end
      default:
        ;
    endcase
  end

endmodule

`default_nettype wire

// ==== refill/icache_refill.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_refill (
  input  wire                                clk_i,
  input  wire                                rst_i,
  input  wire                                miss_i,
  input  wire                                refilling_i,
  input  wire  [31:0]                        lookup_addr_i,
  input  wire                                req_valid_i,
  input  wire                                axi_arready_i,
  input  wire  icache_pkg::axi_r_t           axi_r_i,
  output icache_pkg::axi_ar_t                axi_ar_o,
  output icache_pkg::ram_wr_t                ram_wr_o,
  output logic [icache_pkg::LINE_ADDR_W-1:0] refill_addr_o,
  output logic                               refill_done_o,
  output logic                               req_error_o
);

  logic                               arvalid_q;
  logic                               beat_q;
  logic [31:0]                        lower_q;
  logic [icache_pkg::LINE_ADDR_W-1:0] refill_addr_q;
  logic                               error_q;
  logic                               beat_valid;

  // Beat belongs to our refill
  assign beat_valid = refilling_i && axi_r_i.rvalid;

  //--------------------------------------------------------------------------
  // AR request
  //--------------------------------------------------------------------------
  // Raised on the miss cycle, held until accepted
  assign axi_ar_o.arvalid = miss_i || arvalid_q;
  assign axi_ar_o.araddr  = {lookup_addr_i[31:icache_pkg::LINE_SIZE_W],
                             {icache_pkg::LINE_SIZE_W{1'b0}}};

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      arvalid_q <= 1'b0;
    else
      arvalid_q <= axi_ar_o.arvalid && !axi_arready_i;
  end

  //--------------------------------------------------------------------------
  // Beat assembly
  //--------------------------------------------------------------------------
  // High on the upper beat of a pair
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      beat_q <= 1'b0;
    else if (beat_valid)
      beat_q <= axi_r_i.rlast ? 1'b0 : ~beat_q;
  end

  // Lower word waits one beat
  always_ff @(posedge clk_i)
  begin
    if (axi_r_i.rvalid)
      lower_q <= axi_r_i.rdata;
  end

  // Write address, loaded from the line address on a miss
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      refill_addr_q <= '0;
    else if (miss_i)
      refill_addr_q <= axi_ar_o.araddr[icache_pkg::LINE_SIZE_W +: icache_pkg::LINE_ADDR_W];
    else if (beat_valid && beat_q)
      refill_addr_q <= refill_addr_q + 1'b1;
  end

  assign refill_addr_o = refill_addr_q;

  // Data on every beat, the upper one leaves the full pair
  assign ram_wr_o.data_wr   = beat_valid;
  assign ram_wr_o.data      = {axi_r_i.rdata, lower_q};
  // Tag on the last beat, invalid entry outside a refill for flushes
  assign ram_wr_o.tag_wr    = beat_valid && axi_r_i.rlast;
  assign ram_wr_o.tag.valid = refilling_i;
  assign ram_wr_o.tag.tag   = lookup_addr_i[31 -: icache_pkg::TAG_W];

  assign refill_done_o = beat_valid && axi_r_i.rlast;

  //--------------------------------------------------------------------------
  // Read error
  //--------------------------------------------------------------------------
  // Kept until the fetch is handed back
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      error_q <= 1'b0;
    else if (axi_r_i.rvalid && (axi_r_i.rresp != 2'b00))
      error_q <= 1'b1;
    else if (req_valid_i)
      error_q <= 1'b0;
  end

  assign req_error_o = error_q;

endmodule

`default_nettype wire

// ==== src/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  wire                                clk_i,
  input  wire                                rst_i,
  input  wire                                req_rd_i,
  input  wire                                req_flush_i,
  input  wire                                req_invalidate_i,
  input  wire  [31:0]                        req_pc_i,
  input  wire                                axi_arready_i,
  input  wire  icache_pkg::axi_r_t           axi_r_i,
  output logic                               req_accept_o,
  output logic                               req_valid_o,
  output logic                               req_error_o,
  output logic [icache_pkg::DATA_W-1:0]      req_inst_o,
  output icache_pkg::axi_ar_t                axi_ar_o,
  output logic [7:0]                         axi_arlen_o,
  output logic [1:0]                         axi_arburst_o,
  output logic [3:0]                         axi_arid_o,
  output logic                               axi_rready_o
);

  // Controller outputs
  logic                               miss;
  logic [31:0]                        lookup_addr;
  icache_pkg::line_idx_t              line_idx;
  logic [icache_pkg::LINE_ADDR_W-1:0] data_addr;
  logic [icache_pkg::TAG_W-1:0]       cmp_tag;
  logic                               flush_wr;
  icache_pkg::state_e                 state;

  // Refill outputs
  icache_pkg::ram_wr_t                ram_wr;
  logic [icache_pkg::LINE_ADDR_W-1:0] refill_addr;
  logic                               refill_done;

  // Way results and per-way strobes
  logic                               hit0;
  logic                               hit1;
  logic                               hit_any;
  logic [icache_pkg::DATA_W-1:0]      data0;
  logic [icache_pkg::DATA_W-1:0]      data1;
  logic [icache_pkg::NUM_WAYS-1:0]    tag_wr;
  logic [icache_pkg::NUM_WAYS-1:0]    data_wr;

  // Fixed AR fields, R never stalled
  assign axi_arlen_o   = icache_pkg::AXI_ARLEN;
  assign axi_arburst_o = icache_pkg::AXI_ARBURST;
  assign axi_arid_o    = icache_pkg::AXI_ID;
  assign axi_rready_o  = 1'b1;

  icache_ctrl icache_ctrl_inst (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .req_rd_i         (req_rd_i),
    .req_flush_i      (req_flush_i),
    .req_invalidate_i (req_invalidate_i),
    .req_pc_i         (req_pc_i),
    .hit_any_i        (hit_any),
    .refill_done_i    (refill_done),
    .refill_addr_i    (refill_addr),
    .req_accept_o     (req_accept_o),
    .req_valid_o      (req_valid_o),
    .miss_o           (miss),
    .lookup_addr_o    (lookup_addr),
    .line_idx_o       (line_idx),
    .data_addr_o      (data_addr),
    .cmp_tag_o        (cmp_tag),
    .flush_wr_o       (flush_wr),
    .state_o          (state)
  );

  icache_refill icache_refill_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .miss_i        (miss),
    .refilling_i   (state == icache_pkg::REFILL),
    .lookup_addr_i (lookup_addr),
    .req_valid_i   (req_valid_o),
    .axi_arready_i (axi_arready_i),
    .axi_r_i       (axi_r_i),
    .axi_ar_o      (axi_ar_o),
    .ram_wr_o      (ram_wr),
    .refill_addr_o (refill_addr),
    .refill_done_o (refill_done),
    .req_error_o   (req_error_o)
  );

  icache_way icache_way0_inst (
    .clk_i       (clk_i),
    .line_idx_i  (line_idx),
    .data_addr_i (data_addr),
    .cmp_tag_i   (cmp_tag),
    .tag_wr_i    (tag_wr[0]),
    .data_wr_i   (data_wr[0]),
    .wr_i        (ram_wr),
    .hit_o       (hit0),
    .data_o      (data0)
  );

  icache_way icache_way1_inst (
    .clk_i       (clk_i),
    .line_idx_i  (line_idx),
    .data_addr_i (data_addr),
    .cmp_tag_i   (cmp_tag),
    .tag_wr_i    (tag_wr[1]),
    .data_wr_i   (data_wr[1]),
    .wr_i        (ram_wr),
    .hit_o       (hit1),
    .data_o      (data1)
  );

  icache_way_select icache_way_select_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .hit0_i     (hit0),
    .hit1_i     (hit1),
    .data0_i    (data0),
    .data1_i    (data1),
    .flush_wr_i (flush_wr),
    .wr_i       (ram_wr),
    .hit_any_o  (hit_any),
    .inst_o     (req_inst_o),
    .tag_wr_o   (tag_wr),
    .data_wr_o  (data_wr)
  );

endmodule

`default_nettype wire

// ==== verif/tb_axi_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem (
  input  wire                  clk_i,
  input  wire                  rst_i,
  input  wire  icache_pkg::axi_ar_t ar_i,
  output logic                 arready_o,
  output icache_pkg::axi_r_t   r_o
);

  logic        in_reset;
  logic        take;
  logic [31:0] take_addr;
  logic        busy;
  int          beat_cnt;
  logic [31:0] line_addr;

  // Memory contents, fixed per byte address
  function automatic logic [31:0] beat_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'hC3A5_5A3C;
  endfunction

  initial
  begin
    arready_o = 1'b0;
    r_o       = '0;
    in_reset  = 1'b1;
    take      = 1'b0;
    take_addr = '0;
    busy      = 1'b0;
    beat_cnt  = 0;
    line_addr = '0;
    forever
    begin
      // Bus state over the cycle before the edge
      @(negedge clk_i);
      in_reset  = rst_i;
      take      = ar_i.arvalid && arready_o;
      take_addr = ar_i.araddr;
      @(posedge clk_i);
      #1;
      if (in_reset)
      begin
        arready_o = 1'b0;
        r_o       = '0;
        busy      = 1'b0;
      end
      // Both beats taken, back to idle
      else if (busy && (beat_cnt == 2))
      begin
        r_o       = '0;
        busy      = 1'b0;
        arready_o = 1'b1;
      end
      // One 32-bit beat per cycle, R never stalled
      else if (busy)
      begin
        r_o.rvalid = 1'b1;
        r_o.rdata  = beat_word(line_addr + 32'(beat_cnt * 4));
        r_o.rresp  = (line_addr >= 32'h8000_0000) ? 2'b10 : 2'b00;
        r_o.rlast  = (beat_cnt == 1);
        beat_cnt   = beat_cnt + 1;
      end
      else if (take)
      begin
        busy      = 1'b1;
        beat_cnt  = 0;
        line_addr = take_addr;
        arready_o = 1'b0;
      end
      else
        arready_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

  logic                          clk;
  logic                          rst;
  logic                          req_rd;
  logic                          req_flush;
  logic                          req_invalidate;
  logic [31:0]                   req_pc;
  logic                          req_accept;
  logic                          req_valid;
  logic                          req_error;
  logic [icache_pkg::DATA_W-1:0] req_inst;
  icache_pkg::axi_ar_t           axi_ar;
  logic                          axi_arready;
  icache_pkg::axi_r_t            axi_r;
  logic [7:0]                    axi_arlen;
  logic [1:0]                    axi_arburst;
  logic [3:0]                    axi_arid;
  logic                          axi_rready;

  // Pending results filled by the stimulus and drained by the checker
  logic [icache_pkg::DATA_W-1:0] exp_inst_q [$];
  logic                          exp_err_q  [$];
  logic [31:0]                   exp_ar_q   [$];
  int                            ar_predicted;
  int                            ar_seen;

  // Tag model of 32 sets by 2 ways with one global round-robin pointer
  logic                          shadow_valid [32][2];
  logic [23:0]                   shadow_tag   [32][2];
  logic                          shadow_ptr;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  icache_top icache_top_inst (
    .clk_i            (clk),
    .rst_i            (rst),
    .req_rd_i         (req_rd),
    .req_flush_i      (req_flush),
    .req_invalidate_i (req_invalidate),
    .req_pc_i         (req_pc),
    .axi_arready_i    (axi_arready),
    .axi_r_i          (axi_r),
    .req_accept_o     (req_accept),
    .req_valid_o      (req_valid),
    .req_error_o      (req_error),
    .req_inst_o       (req_inst),
    .axi_ar_o         (axi_ar),
    .axi_arlen_o      (axi_arlen),
    .axi_arburst_o    (axi_arburst),
    .axi_arid_o       (axi_arid),
    .axi_rready_o     (axi_rready)
  );

  tb_axi_mem tb_axi_mem_inst (
    .clk_i     (clk),
    .rst_i     (rst),
    .ar_i      (axi_ar),
    .arready_o (axi_arready),
    .r_o       (axi_r)
  );

  //--------------------------------------------------------------------------
  // Reference model
  //--------------------------------------------------------------------------
  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'hC3A5_5A3C;
  endfunction

  // Word at line base + 4 on top and word at line base below
  function automatic logic [63:0] expected_pair(input logic [31:0] pc);
    logic [31:0] base;
    base = {pc[31:3], 3'b000};
    return {expected_word(base + 32'd4), expected_word(base)};
  endfunction

  function automatic logic shadow_hit(input logic [31:0] pc);
    return (shadow_valid[pc[7:3]][0] && (shadow_tag[pc[7:3]][0] == pc[31:8])) ||
           (shadow_valid[pc[7:3]][1] && (shadow_tag[pc[7:3]][1] == pc[31:8]));
  endfunction

  task automatic shadow_fill(input logic [31:0] pc);
    shadow_valid[pc[7:3]][shadow_ptr] = 1'b1;
    shadow_tag[pc[7:3]][shadow_ptr]   = pc[31:8];
    shadow_ptr = ~shadow_ptr;
  endtask

  //--------------------------------------------------------------------------
  // Compare tasks
  //--------------------------------------------------------------------------
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_inst(input logic [icache_pkg::DATA_W-1:0] got,
                            input logic [icache_pkg::DATA_W-1:0] exp, input string what);
    if (got !== exp)
      stop_on_error($sformatf("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      stop_on_error($sformatf("FAILED at %0d ns: %s is %b, expected %b", $time, what, got, exp));
  endtask

  // Line address plus a fixed INCR burst of two 32-bit beats
  task automatic check_ar(input icache_pkg::axi_ar_t got, input icache_pkg::axi_ar_t exp,
                          input logic [7:0] len, input logic [1:0] burst,
                          input logic [3:0] id);
    if (got !== exp)
      stop_on_error($sformatf("FAILED at %0d ns: AR address %h, expected %h", $time,
                              got.araddr, exp.araddr));
    else if (len !== 8'd1)
      stop_on_error($sformatf("FAILED at %0d ns: arlen is %0d, expected 1", $time, len));
    else if (burst !== 2'b01)
      stop_on_error($sformatf("FAILED at %0d ns: arburst is %b, expected 01", $time,
                              burst));
    else if (id !== icache_pkg::AXI_ID)
      stop_on_error($sformatf("FAILED at %0d ns: arid is %h, expected %h", $time, id,
                              icache_pkg::AXI_ID));
  endtask

  // Result checker on the falling edge
  always @(negedge clk)
  begin
    icache_pkg::axi_ar_t exp_ar;
    if (!rst)
    begin
      check_bit(axi_rready, 1'b1, "axi_rready_o");
      if (req_valid)
      begin
        if (exp_inst_q.size() == 0)
          stop_on_error("req_valid_o pulsed with no fetch outstanding");
        else
        begin
          check_inst(req_inst, exp_inst_q.pop_front(), "instruction pair");
          check_bit(req_error, exp_err_q.pop_front(), "req_error_o");
        end
      end
      if (axi_ar.arvalid && axi_arready)
      begin
        if (exp_ar_q.size() == 0)
          stop_on_error("the cache issued a read request that the tag model did not predict");
        else
        begin
          exp_ar.arvalid = 1'b1;
          exp_ar.araddr  = exp_ar_q.pop_front();
          check_ar(axi_ar, exp_ar, axi_arlen, axi_arburst, axi_arid);
          ar_seen = ar_seen + 1;
        end
      end
    end
  end

  //--------------------------------------------------------------------------
  // Stimulus tasks
  //--------------------------------------------------------------------------
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_accept();
    int cycles;
    cycles = 0;
    while (!req_accept)
    begin
      next_cycle();
      cycles = cycles + 1;
      if (cycles > 200)
        stop_on_error("timed out waiting for req_accept_o");
    end
  endtask

  // Busy for a fixed number of cycles and ready again after
  task automatic check_busy_window(input int cycles, input string what);
    for (int i = 0; i < cycles; i++)
    begin
      check_bit(req_accept, 1'b0, {what, " req_accept_o"});
      check_bit(req_valid, 1'b0, {what, " req_valid_o"});
      check_bit(req_error, 1'b0, {what, " req_error_o"});
      check_bit(axi_ar.arvalid, 1'b0, {what, " arvalid"});
      next_cycle();
    end
    check_bit(req_accept, 1'b1, {what, " req_accept_o at the end"});
  endtask

  task automatic fetch(input logic [31:0] pc);
    logic hit;
    int   cycles;
    hit = shadow_hit(pc);
    exp_inst_q.push_back(expected_pair(pc));
    exp_err_q.push_back(!hit && (pc >= 32'h8000_0000));
    if (!hit)
    begin
      exp_ar_q.push_back({pc[31:3], 3'b000});
      ar_predicted = ar_predicted + 1;
      shadow_fill(pc);
    end
    wait_accept();
    req_rd = 1'b1;
    req_pc = pc;
    next_cycle();
    req_rd = 1'b0;
    if (hit)
      check_bit(req_valid, 1'b1, "req_valid_o the cycle after a hit");
    cycles = 0;
    while (!req_valid)
    begin
      next_cycle();
      cycles = cycles + 1;
      if (cycles > 100)
        stop_on_error($sformatf("timed out waiting for the fetch of %h", pc));
    end
    next_cycle();
    check_bit(req_valid, 1'b0, "req_valid_o one cycle after the valid pulse");
    if (ar_seen != ar_predicted)
      stop_on_error($sformatf("read requests seen %0d, tag model predicts %0d",
                              ar_seen, ar_predicted));
  endtask

  task automatic flush_all();
    wait_accept();
    req_flush = 1'b1;
    next_cycle();
    req_flush = 1'b0;
    for (int s = 0; s < 32; s++)
    begin
      shadow_valid[s][0] = 1'b0;
      shadow_valid[s][1] = 1'b0;
    end
    check_busy_window(32, "flush");
  endtask

  // The whole set is cleared in both ways
  task automatic invalidate_line(input logic [31:0] pc);
    wait_accept();
    req_invalidate = 1'b1;
    req_pc         = pc;
    next_cycle();
    req_invalidate = 1'b0;
    shadow_valid[pc[7:3]][0] = 1'b0;
    shadow_valid[pc[7:3]][1] = 1'b0;
    check_busy_window(1, "invalidate");
  endtask

  //--------------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------------
  initial
  begin
    logic [31:0] pc;
    int          ar_before;
    void'($urandom(15));
    rst            = 1'b1;
    req_rd         = 1'b0;
    req_flush      = 1'b0;
    req_invalidate = 1'b0;
    req_pc         = '0;
    ar_predicted   = 0;
    ar_seen        = 0;
    shadow_ptr     = 1'b0;
    for (int s = 0; s < 32; s++)
    begin
      shadow_valid[s][0] = 1'b0;
      shadow_valid[s][1] = 1'b0;
      shadow_tag[s][0]   = '0;
      shadow_tag[s][1]   = '0;
    end
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    // Flush after reset and the first miss
    check_busy_window(32, "reset flush");
    fetch(32'h0000_1000);
    // Same line hits
    fetch(32'h0000_1004);
    fetch(32'h0000_1000);

    // Three tags in set 5
    fetch(32'h0000_2028);
    fetch(32'h0000_2128);
    fetch(32'h0000_2228);
    // Two newer tags pushed the first line out of set 5
    ar_before = ar_seen;
    fetch(32'h0000_2028);
    if (ar_seen != ar_before + 1)
      stop_on_error("the first line of set 5 was not read again after two newer tags");

    // Invalidate set 0 only and flush everything after
    invalidate_line(32'h0000_1000);
    fetch(32'h0000_2228);
    fetch(32'h0000_1000);
    flush_all();
    fetch(32'h0000_1000);
    fetch(32'h0000_2228);

    // Error region followed by clean fetches
    fetch(32'h8000_0040);
    fetch(32'h8000_0044);
    fetch(32'h0000_1000);

    // Random fetches over 4 tags in 4 sets
    repeat (60)
    begin
      pc = 32'h0000_4000 | (($urandom % 4) << 8) | (($urandom % 4) << 3) |
           (($urandom % 2) << 2);
      fetch(pc);
    end

    if ((exp_inst_q.size() != 0) || (exp_ar_q.size() != 0))
      stop_on_error("fetches or read requests still outstanding at the end");
    else
    begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== compile.f ====
common/icache_pkg.sv
way/icache_way.sv
src/icache_way_select.sv
controller/icache_ctrl.sv
refill/icache_refill.sv
src/icache_top.sv
verif/tb_axi_mem.sv
verif/tb_icache.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it; exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_icache -f compile.f &&
./obj_dir/Vtb_icache ||
{ echo "simulation did not pass"; exit 1; }
